// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// raw instruction word and its fields
	typedef logic [31:0] inst_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	// major opcodes of the supported subset
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OPIMM  = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;

	// branch conditions
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// jalr and the word-sized memory ops
	localparam funct3_t F3_JALR = 3'b000;
	localparam funct3_t F3_LW   = 3'b010;
	localparam funct3_t F3_SW   = 3'b010;

	// alu ops, shared by OP and OP-IMM
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	// srl and sra differ only in funct7
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// funct7 markers
	localparam funct7_t FUNCT7_BASE = 7'b0000000;
	localparam funct7_t FUNCT7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

// File: core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

	// data and address width
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;
	// shift amount taken from operand b
	typedef logic [4:0]      shamt_t;

	// operation performed by the alu
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	// source of the value written to rd
	// RES_IMM is the lui value, RES_LINK is pc+4
	typedef enum logic [1:0] {
		RES_ALU,
		RES_IMM,
		RES_LINK,
		RES_LOAD
	} res_sel_e;

	// control transfer kind, resolved in execute
	typedef enum logic [3:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE,
		BR_BLTU,
		BR_BGEU,
		BR_JAL,
		BR_JALR
	} br_kind_e;

endpackage

`default_nettype wire

// File: inst_decoder.sv
`default_nettype none

module inst_decoder (
	input  rv_isa_pkg::inst_t         inst_i,
	output core_ctrl_pkg::reg_addr_t  rs1_o,
	output core_ctrl_pkg::reg_addr_t  rs2_o,
	output core_ctrl_pkg::reg_addr_t  rd_o,
	output core_ctrl_pkg::word_t      imm_o,
	output core_ctrl_pkg::alu_op_e    alu_op_o,
	output logic                      src_a_pc_o,
	output logic                      src_b_imm_o,
	output core_ctrl_pkg::br_kind_e   br_kind_o,
	output core_ctrl_pkg::res_sel_e   res_sel_o,
	output logic                      rd_write_o,
	output logic                      store_o,
	output logic                      invalid_o
);

	rv_isa_pkg::opcode_t     opcode;
	rv_isa_pkg::funct3_t     funct3;
	rv_isa_pkg::funct7_t     funct7;
	core_ctrl_pkg::word_t    imm_i_type;
	core_ctrl_pkg::word_t    imm_s_type;
	core_ctrl_pkg::word_t    imm_b_type;
	core_ctrl_pkg::word_t    imm_u_type;
	core_ctrl_pkg::word_t    imm_j_type;
	core_ctrl_pkg::alu_op_e  alu_op_f3;
	core_ctrl_pkg::br_kind_e br_req;
	logic                    valid;
	logic                    write_req;
	logic                    store_req;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign rs1_o = inst_i[19:15];
	assign rs2_o = inst_i[24:20];
	assign rd_o  = inst_i[11:7];

	// immediates, all sign extended from bit 31
	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
		inst_i[11:8], 1'b0};
	assign imm_u_type = {inst_i[31:12], 12'b0};
	assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
		inst_i[30:21], 1'b0};

	// base alu op from funct3, sub and sra patched below
	always_comb begin
		case (funct3)
			rv_isa_pkg::F3_ADD:  alu_op_f3 = core_ctrl_pkg::ALU_ADD;
			rv_isa_pkg::F3_SLL:  alu_op_f3 = core_ctrl_pkg::ALU_SLL;
			rv_isa_pkg::F3_SLT:  alu_op_f3 = core_ctrl_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU: alu_op_f3 = core_ctrl_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR:  alu_op_f3 = core_ctrl_pkg::ALU_XOR;
			rv_isa_pkg::F3_SR:   alu_op_f3 = core_ctrl_pkg::ALU_SRL;
			rv_isa_pkg::F3_OR:   alu_op_f3 = core_ctrl_pkg::ALU_OR;
			default:             alu_op_f3 = core_ctrl_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		imm_o       = '0;
		alu_op_o    = core_ctrl_pkg::ALU_ADD;
		src_a_pc_o  = 1'b0;
		src_b_imm_o = 1'b0;
		br_req      = core_ctrl_pkg::BR_NONE;
		res_sel_o   = core_ctrl_pkg::RES_ALU;
		write_req   = 1'b0;
		store_req   = 1'b0;
		valid       = 1'b0;
		case (opcode)
			rv_isa_pkg::OPC_LUI: begin
				imm_o     = imm_u_type;
				res_sel_o = core_ctrl_pkg::RES_IMM;
				write_req = 1'b1;
				valid     = 1'b1;
			end
			rv_isa_pkg::OPC_AUIPC: begin
				imm_o       = imm_u_type;
				src_a_pc_o  = 1'b1;
				src_b_imm_o = 1'b1;
				write_req   = 1'b1;
				valid       = 1'b1;
			end
			rv_isa_pkg::OPC_JAL: begin
				imm_o     = imm_j_type;
				br_req    = core_ctrl_pkg::BR_JAL;
				res_sel_o = core_ctrl_pkg::RES_LINK;
				write_req = 1'b1;
				valid     = 1'b1;
			end
			rv_isa_pkg::OPC_JALR: begin
				// target rs1+imm comes out of the alu adder
				imm_o       = imm_i_type;
				src_b_imm_o = 1'b1;
				br_req      = core_ctrl_pkg::BR_JALR;
				res_sel_o   = core_ctrl_pkg::RES_LINK;
				write_req   = 1'b1;
				valid       = (funct3 == rv_isa_pkg::F3_JALR);
			end
			rv_isa_pkg::OPC_BRANCH: begin
				imm_o = imm_b_type;
				valid = 1'b1;
				case (funct3)
					rv_isa_pkg::F3_BEQ:  br_req = core_ctrl_pkg::BR_BEQ;
					rv_isa_pkg::F3_BNE:  br_req = core_ctrl_pkg::BR_BNE;
					rv_isa_pkg::F3_BLT:  br_req = core_ctrl_pkg::BR_BLT;
					rv_isa_pkg::F3_BGE:  br_req = core_ctrl_pkg::BR_BGE;
					rv_isa_pkg::F3_BLTU: br_req = core_ctrl_pkg::BR_BLTU;
					rv_isa_pkg::F3_BGEU: br_req = core_ctrl_pkg::BR_BGEU;
					default:             valid  = 1'b0;
				endcase
			end
			rv_isa_pkg::OPC_LOAD: begin
				imm_o       = imm_i_type;
				src_b_imm_o = 1'b1;
				res_sel_o   = core_ctrl_pkg::RES_LOAD;
				write_req   = 1'b1;
				valid       = (funct3 == rv_isa_pkg::F3_LW);
			end
			rv_isa_pkg::OPC_STORE: begin
				imm_o       = imm_s_type;
				src_b_imm_o = 1'b1;
				store_req   = 1'b1;
				valid       = (funct3 == rv_isa_pkg::F3_SW);
			end
			rv_isa_pkg::OPC_OPIMM: begin
				imm_o       = imm_i_type;
				src_b_imm_o = 1'b1;
				alu_op_o    = alu_op_f3;
				write_req   = 1'b1;
				valid       = 1'b1;
				// shifts carry funct7 in the upper immediate bits
				if (funct3 == rv_isa_pkg::F3_SLL) begin
					valid = (funct7 == rv_isa_pkg::FUNCT7_BASE);
				end else if (funct3 == rv_isa_pkg::F3_SR) begin
					if (funct7 == rv_isa_pkg::FUNCT7_ALT) begin
						alu_op_o = core_ctrl_pkg::ALU_SRA;
					end else begin
						valid = (funct7 == rv_isa_pkg::FUNCT7_BASE);
					end
				end
			end
			rv_isa_pkg::OPC_OP: begin
				alu_op_o  = alu_op_f3;
				write_req = 1'b1;
				if (funct7 == rv_isa_pkg::FUNCT7_BASE) begin
					valid = 1'b1;
				end else if (funct7 == rv_isa_pkg::FUNCT7_ALT) begin
					if (funct3 == rv_isa_pkg::F3_ADD) begin
						alu_op_o = core_ctrl_pkg::ALU_SUB;
						valid    = 1'b1;
					end else if (funct3 == rv_isa_pkg::F3_SR) begin
						alu_op_o = core_ctrl_pkg::ALU_SRA;
						valid    = 1'b1;
					end
				end
			end
			default: begin
				valid = 1'b0;
			end
		endcase
	end

	// invalid words retire as a plain pc+4 with no side effects
	assign invalid_o  = ~valid;
	assign rd_write_o = write_req & valid & (rd_o != '0);
	assign store_o    = store_req & valid;
	assign br_kind_o  = valid ? br_req : core_ctrl_pkg::BR_NONE;

endmodule

`default_nettype wire

// File: alu_execute.sv
`default_nettype none

module alu_execute (
	input  core_ctrl_pkg::word_t     pc_i,
	input  core_ctrl_pkg::word_t     rs1_data_i,
	input  core_ctrl_pkg::word_t     rs2_data_i,
	input  core_ctrl_pkg::word_t     imm_i,
	input  core_ctrl_pkg::alu_op_e   alu_op_i,
	input  logic                     src_a_pc_i,
	input  logic                     src_b_imm_i,
	input  core_ctrl_pkg::br_kind_e  br_kind_i,
	output core_ctrl_pkg::word_t     alu_result_o,
	output core_ctrl_pkg::word_t     link_o,
	output core_ctrl_pkg::word_t     next_pc_o
);

	core_ctrl_pkg::word_t  op_a;
	core_ctrl_pkg::word_t  op_b;
	core_ctrl_pkg::shamt_t shamt;
	core_ctrl_pkg::word_t  pc_plus_4;
	core_ctrl_pkg::word_t  pc_plus_imm;
	logic                  rs_eq;
	logic                  rs_lt;
	logic                  rs_ltu;
	logic                  taken;

	assign op_a  = src_a_pc_i ? pc_i : rs1_data_i;
	assign op_b  = src_b_imm_i ? imm_i : rs2_data_i;
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op_i)
			core_ctrl_pkg::ALU_ADD:  alu_result_o = op_a + op_b;
			core_ctrl_pkg::ALU_SUB:  alu_result_o = op_a - op_b;
			core_ctrl_pkg::ALU_SLL:  alu_result_o = op_a << shamt;
			core_ctrl_pkg::ALU_SLT:  alu_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
			core_ctrl_pkg::ALU_SLTU: alu_result_o = {31'b0, op_a < op_b};
			core_ctrl_pkg::ALU_XOR:  alu_result_o = op_a ^ op_b;
			core_ctrl_pkg::ALU_SRL:  alu_result_o = op_a >> shamt;
			core_ctrl_pkg::ALU_SRA:  alu_result_o = $unsigned($signed(op_a) >>> shamt);
			core_ctrl_pkg::ALU_OR:   alu_result_o = op_a | op_b;
			default:                 alu_result_o = op_a & op_b;
		endcase
	end

	// branch compare always works on the two register operands
	assign rs_eq  = (rs1_data_i == rs2_data_i);
	assign rs_lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
	assign rs_ltu = (rs1_data_i < rs2_data_i);

	always_comb begin
		case (br_kind_i)
			core_ctrl_pkg::BR_BEQ:  taken = rs_eq;
			core_ctrl_pkg::BR_BNE:  taken = ~rs_eq;
			core_ctrl_pkg::BR_BLT:  taken = rs_lt;
			core_ctrl_pkg::BR_BGE:  taken = ~rs_lt;
			core_ctrl_pkg::BR_BLTU: taken = rs_ltu;
			core_ctrl_pkg::BR_BGEU: taken = ~rs_ltu;
			core_ctrl_pkg::BR_JAL:  taken = 1'b1;
			default:                taken = 1'b0;
		endcase
	end

	assign pc_plus_4   = pc_i + 32'd4;
	assign pc_plus_imm = pc_i + imm_i;
	assign link_o      = pc_plus_4;

	// jalr target is rs1+imm from the alu, low bit dropped
	always_comb begin
		if (br_kind_i == core_ctrl_pkg::BR_JALR) begin
			next_pc_o = {alu_result_o[31:1], 1'b0};
		end else if (taken) begin
			next_pc_o = pc_plus_imm;
		end else begin
			next_pc_o = pc_plus_4;
		end
	end

endmodule

`default_nettype wire

// File: reg_writeback.sv
`default_nettype none

module reg_writeback #(
	parameter int NUM_REGS = 32
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  core_ctrl_pkg::reg_addr_t  rs1_i,
	input  core_ctrl_pkg::reg_addr_t  rs2_i,
	input  core_ctrl_pkg::reg_addr_t  rd_i,
	input  logic                      rd_write_i,
	input  core_ctrl_pkg::res_sel_e   res_sel_i,
	input  core_ctrl_pkg::word_t      alu_result_i,
	input  core_ctrl_pkg::word_t      imm_i,
	input  core_ctrl_pkg::word_t      link_i,
	input  core_ctrl_pkg::word_t      load_data_i,
	output core_ctrl_pkg::word_t      rs1_data_o,
	output core_ctrl_pkg::word_t      rs2_data_o,
	output logic                      wb_en_o,
	output core_ctrl_pkg::reg_addr_t  wb_addr_o,
	output core_ctrl_pkg::word_t      wb_data_o
);

	// index width of the implemented register range
	localparam int IDX_W = $clog2(NUM_REGS);

	core_ctrl_pkg::word_t regs [NUM_REGS];
	logic [IDX_W-1:0]     rs1_idx;
	logic [IDX_W-1:0]     rs2_idx;
	logic [IDX_W-1:0]     wr_idx;

	// upper index bits are dropped, so x16..x31 alias on an rv32e build
	assign rs1_idx = rs1_i[IDX_W-1:0];
	assign rs2_idx = rs2_i[IDX_W-1:0];
	assign wr_idx  = rd_i[IDX_W-1:0];

	// result select
	always_comb begin
		case (res_sel_i)
			core_ctrl_pkg::RES_IMM:  wb_data_o = imm_i;
			core_ctrl_pkg::RES_LINK: wb_data_o = link_i;
			core_ctrl_pkg::RES_LOAD: wb_data_o = load_data_i;
			default:                 wb_data_o = alu_result_i;
		endcase
	end

	// no retire while reset is held
	assign wb_en_o   = rd_write_i & rst_n_i;
	assign wb_addr_o = rd_i;

	// entry 0 is never written and stays zero
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en_o && (wr_idx != '0)) begin
			regs[wr_idx] <= wb_data_o;
		end
	end

	// read ports, no bypass since the write lands at the edge
	assign rs1_data_o = regs[rs1_idx];
	assign rs2_data_o = regs[rs2_idx];

endmodule

`default_nettype wire

// File: rv_core_top.sv
`default_nettype none

module rv_core_top #(
	parameter int                   NUM_REGS = 32,
	parameter core_ctrl_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	output core_ctrl_pkg::word_t      pc_o,
	input  rv_isa_pkg::inst_t         inst_i,
	output core_ctrl_pkg::word_t      dmem_addr_o,
	output logic                      dmem_we_o,
	output core_ctrl_pkg::word_t      dmem_wdata_o,
	input  core_ctrl_pkg::word_t      dmem_rdata_i,
	output logic                      invalid_o,
	output logic                      wb_en_o,
	output core_ctrl_pkg::reg_addr_t  wb_addr_o,
	output core_ctrl_pkg::word_t      wb_data_o
);

	core_ctrl_pkg::word_t     pc_q;
	core_ctrl_pkg::word_t     next_pc;
	core_ctrl_pkg::reg_addr_t rs1;
	core_ctrl_pkg::reg_addr_t rs2;
	core_ctrl_pkg::reg_addr_t rd;
	core_ctrl_pkg::word_t     imm;
	core_ctrl_pkg::alu_op_e   alu_op;
	logic                     src_a_pc;
	logic                     src_b_imm;
	core_ctrl_pkg::br_kind_e  br_kind;
	core_ctrl_pkg::res_sel_e  res_sel;
	logic                     rd_write;
	logic                     store;
	core_ctrl_pkg::word_t     rs1_data;
	core_ctrl_pkg::word_t     rs2_data;
	core_ctrl_pkg::word_t     alu_result;
	core_ctrl_pkg::word_t     link;

	// one instruction retires per edge
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= RESET_PC;
		end else begin
			pc_q <= next_pc;
		end
	end

	assign pc_o = pc_q;

	inst_decoder u_decoder (
		.inst_i      (inst_i),
		.rs1_o       (rs1),
		.rs2_o       (rs2),
		.rd_o        (rd),
		.imm_o       (imm),
		.alu_op_o    (alu_op),
		.src_a_pc_o  (src_a_pc),
		.src_b_imm_o (src_b_imm),
		.br_kind_o   (br_kind),
		.res_sel_o   (res_sel),
		.rd_write_o  (rd_write),
		.store_o     (store),
		.invalid_o   (invalid_o)
	);

	alu_execute u_execute (
		.pc_i         (pc_q),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.imm_i        (imm),
		.alu_op_i     (alu_op),
		.src_a_pc_i   (src_a_pc),
		.src_b_imm_i  (src_b_imm),
		.br_kind_i    (br_kind),
		.alu_result_o (alu_result),
		.link_o       (link),
		.next_pc_o    (next_pc)
	);

	reg_writeback #(
		.NUM_REGS (NUM_REGS)
	) u_writeback (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.rs1_i        (rs1),
		.rs2_i        (rs2),
		.rd_i         (rd),
		.rd_write_i   (rd_write),
		.res_sel_i    (res_sel),
		.alu_result_i (alu_result),
		.imm_i        (imm),
		.link_i       (link),
		.load_data_i  (dmem_rdata_i),
		.rs1_data_o   (rs1_data),
		.rs2_data_o   (rs2_data),
		.wb_en_o      (wb_en_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o)
	);

	// data port, address from the alu adder for both lw and sw
	assign dmem_addr_o  = alu_result;
	assign dmem_wdata_o = rs2_data;
	assign dmem_we_o    = store & rst_n_i;

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	// period of 20
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// reset held for the first 10 cycles
	initial begin
		rst_n_o = 1'b0;
		repeat (10) @(posedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// File: rv_core_chk.sv
`default_nettype none

module rv_core_chk #(
	parameter int                   NUM_REGS = 32,
	parameter core_ctrl_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input logic                      clk,
	input logic                      rst_n_i,
	input core_ctrl_pkg::word_t      pc_o,
	input rv_isa_pkg::inst_t         inst_i,
	input core_ctrl_pkg::word_t      dmem_addr_o,
	input logic                      dmem_we_o,
	input core_ctrl_pkg::word_t      dmem_wdata_o,
	input core_ctrl_pkg::word_t      dmem_rdata_i,
	input logic                      invalid_o,
	input logic                      wb_en_o,
	input core_ctrl_pkg::reg_addr_t  wb_addr_o,
	input core_ctrl_pkg::word_t      wb_data_o
);

	core_ctrl_pkg::word_t shadow [32];
	core_ctrl_pkg::word_t op_a;
	core_ctrl_pkg::word_t op_b;
	core_ctrl_pkg::word_t imm_i;
	core_ctrl_pkg::word_t imm_s;
	core_ctrl_pkg::word_t imm_b;
	core_ctrl_pkg::word_t imm_j;
	core_ctrl_pkg::word_t exp_data;
	core_ctrl_pkg::word_t exp_npc;
	core_ctrl_pkg::word_t exp_addr;
	rv_isa_pkg::funct3_t  f3;
	rv_isa_pkg::funct7_t  f7;
	logic                 exp_valid;
	logic                 exp_we;
	logic                 exp_st;
	logic                 exp_ld;
	logic                 taken;
	logic                 failed = 1'b0;

	// registers above NUM_REGS alias onto the low ones
	function automatic core_ctrl_pkg::word_t shadow_read(core_ctrl_pkg::reg_addr_t r);
		int idx;
		idx = int'(r) % NUM_REGS;
		return (idx == 0) ? 32'd0 : shadow[idx];
	endfunction

	function automatic core_ctrl_pkg::word_t alu_ref(rv_isa_pkg::funct3_t op, logic alt,
		core_ctrl_pkg::word_t a, core_ctrl_pkg::word_t b);
		case (op)
			rv_isa_pkg::F3_ADD:  return alt ? a - b : a + b;
			rv_isa_pkg::F3_SLL:  return a << b[4:0];
			rv_isa_pkg::F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			rv_isa_pkg::F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
			rv_isa_pkg::F3_XOR:  return a ^ b;
			rv_isa_pkg::F3_SR:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			rv_isa_pkg::F3_OR:   return a | b;
			default:             return a & b;
		endcase
	endfunction

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				shadow[i] <= '0;
			end
		end else if (wb_en_o && (int'(wb_addr_o) % NUM_REGS != 0)) begin
			shadow[int'(wb_addr_o) % NUM_REGS] <= wb_data_o;
		end
	end

	// reference model straight from the isa rules
	always_comb begin
		f3 = inst_i[14:12];
		f7 = inst_i[31:25];
		op_a = shadow_read(inst_i[19:15]);
		op_b = shadow_read(inst_i[24:20]);
		imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
		imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
		imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
		imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
		case (f3)
			rv_isa_pkg::F3_BEQ:  taken = (op_a == op_b);
			rv_isa_pkg::F3_BNE:  taken = (op_a != op_b);
			rv_isa_pkg::F3_BLT:  taken = ($signed(op_a) < $signed(op_b));
			rv_isa_pkg::F3_BGE:  taken = ($signed(op_a) >= $signed(op_b));
			rv_isa_pkg::F3_BLTU: taken = (op_a < op_b);
			rv_isa_pkg::F3_BGEU: taken = (op_a >= op_b);
			default:             taken = 1'b0;
		endcase
		exp_valid = 1'b0;
		exp_we = 1'b0;
		exp_st = 1'b0;
		exp_ld = 1'b0;
		exp_data = '0;
		exp_npc = pc_o + 32'd4;
		exp_addr = op_a + imm_s;
		case (inst_i[6:0])
			rv_isa_pkg::OPC_LUI: begin
				exp_valid = 1'b1;
				exp_we = 1'b1;
				exp_data = {inst_i[31:12], 12'b0};
			end
			rv_isa_pkg::OPC_AUIPC: begin
				exp_valid = 1'b1;
				exp_we = 1'b1;
				exp_data = pc_o + {inst_i[31:12], 12'b0};
			end
			rv_isa_pkg::OPC_JAL: begin
				exp_valid = 1'b1;
				exp_we = 1'b1;
				exp_data = pc_o + 32'd4;
				exp_npc = pc_o + imm_j;
			end
			rv_isa_pkg::OPC_JALR: begin
				exp_valid = (f3 == rv_isa_pkg::F3_JALR);
				exp_we = 1'b1;
				exp_data = pc_o + 32'd4;
				exp_npc = (op_a + imm_i) & ~32'd1;
			end
			rv_isa_pkg::OPC_BRANCH: begin
				exp_valid = (f3 != 3'b010) && (f3 != 3'b011);
				if (taken) begin
					exp_npc = pc_o + imm_b;
				end
			end
			rv_isa_pkg::OPC_LOAD: begin
				exp_valid = (f3 == rv_isa_pkg::F3_LW);
				exp_we = 1'b1;
				exp_ld = 1'b1;
				exp_addr = op_a + imm_i;
				exp_data = dmem_rdata_i;
			end
			rv_isa_pkg::OPC_STORE: begin
				exp_valid = (f3 == rv_isa_pkg::F3_SW);
				exp_st = 1'b1;
			end
			rv_isa_pkg::OPC_OPIMM: begin
				exp_valid = ((f3 != rv_isa_pkg::F3_SLL) && (f3 != rv_isa_pkg::F3_SR))
					|| (f7 == rv_isa_pkg::FUNCT7_BASE)
					|| ((f3 == rv_isa_pkg::F3_SR) && (f7 == rv_isa_pkg::FUNCT7_ALT));
				exp_we = 1'b1;
				exp_data = alu_ref(f3, (f3 == rv_isa_pkg::F3_SR) && inst_i[30], op_a, imm_i);
			end
			rv_isa_pkg::OPC_OP: begin
				exp_valid = (f7 == rv_isa_pkg::FUNCT7_BASE) || ((f7 == rv_isa_pkg::FUNCT7_ALT)
					&& ((f3 == rv_isa_pkg::F3_ADD) || (f3 == rv_isa_pkg::F3_SR)));
				exp_we = 1'b1;
				exp_data = alu_ref(f3, inst_i[30], op_a, op_b);
			end
			default: begin
				exp_valid = 1'b0;
			end
		endcase
		// invalid words just fall through
		if (!exp_valid) begin
			exp_we = 1'b0;
			exp_st = 1'b0;
			exp_ld = 1'b0;
			exp_npc = pc_o + 32'd4;
		end
		if (inst_i[11:7] == 5'd0) begin
			exp_we = 1'b0;
		end
	end

	a_reset: assert property (@(posedge clk) !rst_n_i |-> (pc_o == RESET_PC) && !wb_en_o
		&& !dmem_we_o)
	else begin
		failed = 1'b1;
		$error("error %0t pc_o %h expected %h, wb_en_o %b dmem_we_o %b expected 0 in reset",
			$time, $sampled(pc_o), RESET_PC, $sampled(wb_en_o), $sampled(dmem_we_o));
	end

	a_first_pc: assert property (@(posedge clk) $rose(rst_n_i) |-> pc_o == RESET_PC)
	else begin
		failed = 1'b1;
		$error("error %0t pc_o %h expected %h", $time, $sampled(pc_o), RESET_PC);
	end

	a_invalid: assert property (@(posedge clk) disable iff (!rst_n_i) invalid_o == !exp_valid)
	else begin
		failed = 1'b1;
		$error("error %0t invalid_o %b expected %b", $time, $sampled(invalid_o),
			!$sampled(exp_valid));
	end

	a_wb_en: assert property (@(posedge clk) disable iff (!rst_n_i) wb_en_o == exp_we)
	else begin
		failed = 1'b1;
		$error("error %0t wb_en_o %b expected %b", $time, $sampled(wb_en_o), $sampled(exp_we));
	end

	a_wb_data: assert property (@(posedge clk) disable iff (!rst_n_i)
		exp_we |-> (wb_addr_o == inst_i[11:7]) && (wb_data_o == exp_data))
	else begin
		failed = 1'b1;
		$error("error %0t wb_data_o %h expected %h at rd %0d", $time, $sampled(wb_data_o),
			$sampled(exp_data), $sampled(wb_addr_o));
	end

	a_load_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
		exp_ld |-> dmem_addr_o == exp_addr)
	else begin
		failed = 1'b1;
		$error("error %0t dmem_addr_o %h expected %h", $time, $sampled(dmem_addr_o),
			$sampled(exp_addr));
	end

	a_store_en: assert property (@(posedge clk) disable iff (!rst_n_i) dmem_we_o == exp_st)
	else begin
		failed = 1'b1;
		$error("error %0t dmem_we_o %b expected %b", $time, $sampled(dmem_we_o),
			$sampled(exp_st));
	end

	a_store_data: assert property (@(posedge clk) disable iff (!rst_n_i)
		exp_st |-> (dmem_addr_o == exp_addr) && (dmem_wdata_o == op_b))
	else begin
		failed = 1'b1;
		$error("error %0t dmem_addr_o %h expected %h, dmem_wdata_o %h expected %h", $time,
			$sampled(dmem_addr_o), $sampled(exp_addr), $sampled(dmem_wdata_o),
			$sampled(op_b));
	end

	// next pc shows up one edge later
	a_next_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
		rst_n_i |=> pc_o == $past(exp_npc))
	else begin
		failed = 1'b1;
		$error("error %0t pc_o %h expected %h", $time, $sampled(pc_o), $past(exp_npc));
	end

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`default_nettype none

module tb_rv_core;

	localparam int                   NUM_REGS = 16;
	localparam core_ctrl_pkg::word_t RESET_PC = 32'h0000_0000;
	localparam int                   IMEM_WORDS = 1024;
	localparam int                   RUN_LEN = 2000;
	localparam int                   RESET_TIMEOUT = 100;

	logic                      clk;
	logic                      rst_n;
	core_ctrl_pkg::word_t      pc;
	rv_isa_pkg::inst_t         inst;
	core_ctrl_pkg::word_t      dmem_addr;
	logic                      dmem_we;
	core_ctrl_pkg::word_t      dmem_wdata;
	core_ctrl_pkg::word_t      dmem_rdata;
	logic                      invalid;
	logic                      wb_en;
	core_ctrl_pkg::reg_addr_t  wb_addr;
	core_ctrl_pkg::word_t      wb_data;
	rv_isa_pkg::inst_t         imem [IMEM_WORDS];
	core_ctrl_pkg::word_t      dmem [256];

	tb_clock_gen u_clock (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	rv_core_top #(
		.NUM_REGS (NUM_REGS),
		.RESET_PC (RESET_PC)
	) uut (
		.clk          (clk),
		.rst_n_i      (rst_n),
		.pc_o         (pc),
		.inst_i       (inst),
		.dmem_addr_o  (dmem_addr),
		.dmem_we_o    (dmem_we),
		.dmem_wdata_o (dmem_wdata),
		.dmem_rdata_i (dmem_rdata),
		.invalid_o    (invalid),
		.wb_en_o      (wb_en),
		.wb_addr_o    (wb_addr),
		.wb_data_o    (wb_data)
	);

	bind rv_core_top rv_core_chk #(
		.NUM_REGS (NUM_REGS),
		.RESET_PC (RESET_PC)
	) u_chk (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.pc_o         (pc_o),
		.inst_i       (inst_i),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_rdata_i (dmem_rdata_i),
		.invalid_o    (invalid_o),
		.wb_en_o      (wb_en_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o)
	);

	// combinational memories, write at the edge
	assign inst       = imem[pc[11:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		end
	end

	// mostly valid encodings, targets kept inside the table
	function automatic rv_isa_pkg::inst_t random_inst(int slot);
		logic [31:0] r;
		logic [11:0] imm12;
		logic [12:0] boff;
		logic [20:0] joff;
		rv_isa_pkg::funct3_t f3;
		rv_isa_pkg::funct7_t f7;
		int target;
		r = $urandom;
		f3 = r[17:15];
		imm12 = r[29:18];
		target = int'($urandom % IMEM_WORDS);
		boff = 13'((target - slot) * 4);
		joff = 21'((target - slot) * 4);
		f7 = (r[30] && ((f3 == rv_isa_pkg::F3_ADD) || (f3 == rv_isa_pkg::F3_SR))) ?
			rv_isa_pkg::FUNCT7_ALT : rv_isa_pkg::FUNCT7_BASE;
		case ($urandom % 16)
			0: return {r[31:12], r[4:0], rv_isa_pkg::OPC_LUI};
			1: return {r[31:12], r[4:0], rv_isa_pkg::OPC_AUIPC};
			2: return {joff[20], joff[10:1], joff[11], joff[19:12], r[4:0], rv_isa_pkg::OPC_JAL};
			3: return {imm12, r[9:5], rv_isa_pkg::F3_JALR, r[4:0], rv_isa_pkg::OPC_JALR};
			4, 5: return {boff[12], boff[10:5], r[14:10], r[9:5], f3, boff[4:1], boff[11],
				rv_isa_pkg::OPC_BRANCH};
			6: return {imm12, r[9:5], rv_isa_pkg::F3_LW, r[4:0], rv_isa_pkg::OPC_LOAD};
			7: return {imm12[11:5], r[14:10], r[9:5], rv_isa_pkg::F3_SW, imm12[4:0],
				rv_isa_pkg::OPC_STORE};
			8, 9, 10: begin
				if ((f3 == rv_isa_pkg::F3_SLL) || (f3 == rv_isa_pkg::F3_SR)) begin
					imm12[11:5] = (f3 == rv_isa_pkg::F3_SR) ? f7 : rv_isa_pkg::FUNCT7_BASE;
				end
				return {imm12, r[9:5], f3, r[4:0], rv_isa_pkg::OPC_OPIMM};
			end
			11, 12, 13: return {f7, r[14:10], r[9:5], f3, r[4:0], rv_isa_pkg::OPC_OP};
			// ecall, outside the supported set
			14: return 32'h0000_0073;
			default: return $urandom;
		endcase
	endfunction

	// first assertion failure ends the run
	always @(posedge uut.u_chk.failed) begin
		$display("Simulation finished: FAIL");
		$fatal(1, "assertion failure reported by the checker");
	end

	initial begin
		int wait_cycles;
		int retired;
		void'($urandom(23228));
		for (int k = 0; k < IMEM_WORDS; k++) begin
			imem[k] = random_inst(k);
		end
		for (int k = 0; k < 256; k++) begin
			dmem[k] = 32'h9e37_79b9 * 32'(k + 1);
		end
		wait_cycles = 0;
		while ((rst_n !== 1'b1) && wait_cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was never released");
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout waiting for reset release");
		end
		// one retire per edge, the count bounds the loop
		retired = 0;
		while (retired < RUN_LEN && !uut.u_chk.failed) begin
			@(posedge clk);
			retired++;
		end
		@(negedge clk);
		if (uut.u_chk.failed) begin
			$display("Simulation finished: FAIL");
			$fatal(1, "checker flagged an error");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: all.f
rv_isa_pkg.sv
core_ctrl_pkg.sv
inst_decoder.sv
alu_execute.sv
reg_writeback.sv
rv_core_top.sv
tb_clock_gen.sv
rv_core_chk.sv
tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rv_core -f all.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
fi
exit $status
